// ==== rv_csr_consts.svh ====
`ifndef RV_CSR_CONSTS_SVH
`define RV_CSR_CONSTS_SVH

`define CSR_XLEN              32
`define CSR_MACHINE_PAGE      4'h3          // Address bits 11:8 of machine CSRs

// Low byte of the machine CSR address
`define CSR_IDX_MSTATUS       8'h00
`define CSR_IDX_MISA          8'h01
`define CSR_IDX_MIE           8'h04
`define CSR_IDX_MTVEC         8'h05
`define CSR_IDX_MCOUNTEREN    8'h06
`define CSR_IDX_MSTATUSH      8'h10
`define CSR_IDX_MSCRATCH      8'h40
`define CSR_IDX_MEPC          8'h41
`define CSR_IDX_MCAUSE        8'h42
`define CSR_IDX_MTVAL         8'h43
`define CSR_IDX_MIP           8'h44

`define CSR_F3_RW             3'd1          // Register source forms
`define CSR_F3_RS             3'd2
`define CSR_F3_RC             3'd3
`define CSR_F3_RWI            3'd5          // Immediate source forms
`define CSR_F3_RSI            3'd6
`define CSR_F3_RCI            3'd7

`define CAUSE_BREAKPOINT      8'd3

`define IRQ_CODE_SOFT         3             // Also the mip/mie bit positions
`define IRQ_CODE_TIMER        7
`define IRQ_CODE_EXTERNAL     11

`define MTVEC_MODE_DIRECT     2'd0
`define MTVEC_MODE_VECTORED   2'd1

`endif

// ==== rv_csr_pkg.sv ====
`include "rv_csr_consts.svh"

package rv_csr_pkg;

    typedef logic [`CSR_XLEN-1:0] csr_word_t;       // CSR data word

    typedef logic [7:0]           csr_idx_t;        // Index inside the machine page

    typedef logic [11:0]          csr_addr_t;       // Full CSR address

    typedef logic [2:0]           csr_funct3_t;     // Zicsr function code

    typedef logic [7:0]           cause_code_t;     // Exception or interrupt code

    typedef logic [11:0]          irq_vec_t;        // mip / mie field

endpackage

// ==== rv_csr_reg.sv ====
`timescale 1ns/1ps

`include "rv_csr_consts.svh"

module rv_csr_reg
#(
    parameter int WIDTH = `CSR_XLEN                     // Implemented low bits
)
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_sel,
    input  rv_csr_pkg::csr_word_t i_data,
    input  logic                  i_write,
    input  logic                  i_set,
    input  logic                  i_clear,
    output rv_csr_pkg::csr_word_t o_data
);
    import rv_csr_pkg::*;

    logic [WIDTH-1:0] value_q;                          // Stored bits only

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            value_q <= '0;
        else if (i_sel)
        begin
            if (i_write)
                value_q <= i_data[WIDTH-1:0];           // Replace
            else if (i_set)
                value_q <= value_q | i_data[WIDTH-1:0]; // OR in mask
            else if (i_clear)
                value_q <= value_q & ~i_data[WIDTH-1:0]; // Knock out mask bits
        end
    end

    assign o_data = csr_word_t'(value_q);               // Unimplemented bits read zero

endmodule

// ==== rv_csr_access.sv ====
`timescale 1ns/1ps

`include "rv_csr_consts.svh"

module rv_csr_access
(
    input  logic                    i_csr_valid,
    input  rv_csr_pkg::csr_funct3_t i_funct3,
    input  rv_csr_pkg::csr_addr_t   i_csr_addr,
    input  logic [4:0]              i_rs1_idx,
    input  rv_csr_pkg::csr_word_t   i_rs1_data,
    output logic                    o_sel,
    output rv_csr_pkg::csr_idx_t    o_idx,
    output rv_csr_pkg::csr_word_t   o_data,
    output logic                    o_write,
    output logic                    o_set,
    output logic                    o_clear,
    output logic                    o_illegal
);
    import rv_csr_pkg::*;

    logic page_ok;                                      // Address in machine page
    logic op_write;
    logic op_set;
    logic op_clear;
    logic op_bad;                                       // Undefined funct3
    logic src_nonzero;                                  // rs1 index or uimm not zero

    assign page_ok     = (i_csr_addr[11:8] == `CSR_MACHINE_PAGE);
    assign src_nonzero = |i_rs1_idx;

    always_comb
    begin
        op_write = 1'b0;
        op_set   = 1'b0;
        op_clear = 1'b0;
        op_bad   = 1'b0;
        case (i_funct3)
            `CSR_F3_RW,  `CSR_F3_RWI: op_write = 1'b1;
            `CSR_F3_RS,  `CSR_F3_RSI: op_set   = 1'b1;
            `CSR_F3_RC,  `CSR_F3_RCI: op_clear = 1'b1;
            default:                  op_bad   = 1'b1;
        endcase
    end

    // Bit 2 of funct3 marks the immediate forms
    assign o_data = i_funct3[2] ? csr_word_t'(i_rs1_idx) : i_rs1_data;

    assign o_idx     = i_csr_addr[7:0];
    assign o_illegal = i_csr_valid & (~page_ok | op_bad);
    assign o_sel     = i_csr_valid & page_ok & ~op_bad;
    assign o_write   = o_sel & op_write;
    assign o_set     = o_sel & op_set & src_nonzero;    // Zero source reads only
    assign o_clear   = o_sel & op_clear & src_nonzero;

endmodule

// ==== rv_int_ctrl.sv ====
`timescale 1ns/1ps

`include "rv_csr_consts.svh"

module rv_int_ctrl
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_irq_external,
    input  logic                    i_irq_timer,
    input  logic                    i_irq_soft,
    input  logic                    i_enable_external,
    input  logic                    i_enable_timer,
    input  logic                    i_enable_soft,
    output logic                    o_pending_external,
    output logic                    o_pending_timer,
    output logic                    o_pending_soft,
    output logic                    o_irq,
    output rv_csr_pkg::cause_code_t o_irq_cause
);
    import rv_csr_pkg::*;

    logic active_external;                              // Pending and enabled
    logic active_timer;
    logic active_soft;

    // Single register stage on the raw request lines
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_pending_external <= 1'b0;
            o_pending_timer    <= 1'b0;
            o_pending_soft     <= 1'b0;
        end
        else
        begin
            o_pending_external <= i_irq_external;
            o_pending_timer    <= i_irq_timer;
            o_pending_soft     <= i_irq_soft;
        end
    end

    assign active_external = o_pending_external & i_enable_external;
    assign active_timer    = o_pending_timer & i_enable_timer;
    assign active_soft     = o_pending_soft & i_enable_soft;

    assign o_irq = active_external | active_timer | active_soft;

    always_comb
    begin
        if (active_external)                            // Highest priority
            o_irq_cause = cause_code_t'(`IRQ_CODE_EXTERNAL);
        else if (active_soft)
            o_irq_cause = cause_code_t'(`IRQ_CODE_SOFT);
        else if (active_timer)                          // Lowest priority
            o_irq_cause = cause_code_t'(`IRQ_CODE_TIMER);
        else
            o_irq_cause = '0;
    end

endmodule

// ==== rv_csr_machine.sv ====
`timescale 1ns/1ps

`include "rv_csr_consts.svh"

module rv_csr_machine
#(
    parameter int EXTENSION_C      = 0,
    parameter int EXTENSION_Zicntr = 0,
    parameter int EXTENSION_Zihpm  = 0
)
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_sel,
    input  rv_csr_pkg::csr_idx_t  i_idx,
    input  rv_csr_pkg::csr_word_t i_data,
    input  logic                  i_write,
    input  logic                  i_set,
    input  logic                  i_clear,
    input  rv_csr_pkg::csr_word_t i_pc,
    input  logic                  i_ebreak,
    input  logic                  i_pending_external,
    input  logic                  i_pending_timer,
    input  logic                  i_pending_soft,
    output logic                  o_enable_external,
    output logic                  o_enable_timer,
    output logic                  o_enable_soft,
    output rv_csr_pkg::csr_word_t o_ret_addr,
    output rv_csr_pkg::csr_word_t o_trap_pc,
    output rv_csr_pkg::csr_word_t o_data
);
    import rv_csr_pkg::*;

    localparam int NUM_FULL = 5;                        // Plain 32-bit storage registers

    wire sel_mstatus    = i_sel && (i_idx == `CSR_IDX_MSTATUS);
    wire sel_mie        = i_sel && (i_idx == `CSR_IDX_MIE);
    wire sel_mtvec      = i_sel && (i_idx == `CSR_IDX_MTVEC);
    wire sel_mcounteren = i_sel && (i_idx == `CSR_IDX_MCOUNTEREN);
    wire sel_mstatush   = i_sel && (i_idx == `CSR_IDX_MSTATUSH);
    wire sel_mscratch   = i_sel && (i_idx == `CSR_IDX_MSCRATCH);
    wire sel_mepc       = i_sel && (i_idx == `CSR_IDX_MEPC);
    wire sel_mtval      = i_sel && (i_idx == `CSR_IDX_MTVAL);

    logic [NUM_FULL-1:0] full_sel;                      // Selects of the plain registers
    csr_word_t           full_data [NUM_FULL];

    csr_word_t   mstatus_data;
    csr_word_t   mstatush_data;
    csr_word_t   mtvec_data;
    csr_word_t   mscratch_data;
    csr_word_t   mtval_data;
    csr_word_t   mie_data;
    csr_word_t   misa_data;
    csr_word_t   mepc_data;
    cause_code_t mcause_code;
    csr_word_t   mcause_data;
    csr_word_t   mcounteren_lo;
    csr_word_t   mcounteren_hi;
    irq_vec_t    mip_data;
    csr_word_t   trap_base;

    // Slot order mstatus, mstatush, mtvec, mscratch, mtval
    assign full_sel = {sel_mtval, sel_mscratch, sel_mtvec, sel_mstatush, sel_mstatus};

    generate
        for (genvar g = 0; g < NUM_FULL; g++)
        begin : g_full
            rv_csr_reg #(.WIDTH(`CSR_XLEN)) u_reg
            (
                .i_clk     (i_clk),
                .i_reset_n (i_reset_n),
                .i_sel     (full_sel[g]),
                .i_data    (i_data),
                .i_write   (i_write),
                .i_set     (i_set),
                .i_clear   (i_clear),
                .o_data    (full_data[g])
            );
        end
    endgenerate

    assign mstatus_data  = full_data[0];                // No MIE/MPIE stacking here
    assign mstatush_data = full_data[1];
    assign mtvec_data    = full_data[2];
    assign mscratch_data = full_data[3];
    assign mtval_data    = full_data[4];

    rv_csr_reg #(.WIDTH(12)) u_mie                      // Machine interrupt enable
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_sel     (sel_mie),
        .i_data    (i_data),
        .i_write   (i_write),
        .i_set     (i_set),
        .i_clear   (i_clear),
        .o_data    (mie_data)
    );

    generate
        if (EXTENSION_Zicntr != 0)
        begin : g_cnt_lo
            rv_csr_reg #(.WIDTH(3)) u_mcounteren_lo     // CY, TM, IR enables
            (
                .i_clk     (i_clk),
                .i_reset_n (i_reset_n),
                .i_sel     (sel_mcounteren),
                .i_data    (i_data),
                .i_write   (i_write),
                .i_set     (i_set),
                .i_clear   (i_clear),
                .o_data    (mcounteren_lo)
            );
        end
        else
        begin : g_no_cnt_lo
            assign mcounteren_lo = '0;
        end

        if (EXTENSION_Zihpm != 0)
        begin : g_cnt_hi
            csr_word_t hi_data;                         // HPM enables, stored from bit 0

            rv_csr_reg #(.WIDTH(29)) u_mcounteren_hi
            (
                .i_clk     (i_clk),
                .i_reset_n (i_reset_n),
                .i_sel     (sel_mcounteren),
                .i_data    (i_data >> 3),               // Align bit 3 to storage bit 0
                .i_write   (i_write),
                .i_set     (i_set),
                .i_clear   (i_clear),
                .o_data    (hi_data)
            );
            assign mcounteren_hi = {hi_data[28:0], 3'b000};
        end
        else
        begin : g_no_cnt_hi
            assign mcounteren_hi = '0;
        end
    endgenerate

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            mepc_data <= '0;
        else if (i_ebreak)
            mepc_data <= i_pc;                          // Trap wins over CSR write
        else if (sel_mepc && i_write)
            mepc_data <= i_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            mcause_code <= '0;
        else if (i_ebreak)
            mcause_code <= `CAUSE_BREAKPOINT;           // Only trap source
    end

    assign mcause_data = csr_word_t'(mcause_code);      // Interrupt flag always clear

    // MXL=1 at 31:30, I at bit 8, C at bit 2
    assign misa_data = {2'b01, 21'b0, 1'b1, 5'b0, (EXTENSION_C != 0), 2'b00};

    always_comb
    begin
        mip_data                     = '0;
        mip_data[`IRQ_CODE_EXTERNAL] = i_pending_external; // MEIP
        mip_data[`IRQ_CODE_TIMER]    = i_pending_timer;    // MTIP
        mip_data[`IRQ_CODE_SOFT]     = i_pending_soft;     // MSIP
    end

    assign o_enable_external = mie_data[`IRQ_CODE_EXTERNAL]; // MEIE
    assign o_enable_timer    = mie_data[`IRQ_CODE_TIMER];    // MTIE
    assign o_enable_soft     = mie_data[`IRQ_CODE_SOFT];     // MSIE

    assign trap_base = {mtvec_data[31:2], 2'b00};       // Mode bits stripped

    always_comb
    begin
        case (mtvec_data[1:0])
            `MTVEC_MODE_DIRECT:   o_trap_pc = trap_base;
            `MTVEC_MODE_VECTORED: o_trap_pc = trap_base + {mcause_data[29:0], 2'b00};
            default:              o_trap_pc = '0;   // Reserved modes
        endcase
    end

    assign o_ret_addr = mepc_data;

    always_comb
    begin
        o_data = '0;
        if (i_sel)
        begin
            case (i_idx)
                `CSR_IDX_MSTATUS:    o_data = mstatus_data;
                `CSR_IDX_MISA:       o_data = misa_data;
                `CSR_IDX_MIE:        o_data = mie_data;
                `CSR_IDX_MTVEC:      o_data = mtvec_data;
                `CSR_IDX_MCOUNTEREN: o_data = mcounteren_hi | mcounteren_lo;
                `CSR_IDX_MSTATUSH:   o_data = mstatush_data;
                `CSR_IDX_MSCRATCH:   o_data = mscratch_data;
                `CSR_IDX_MEPC:       o_data = mepc_data;
                `CSR_IDX_MCAUSE:     o_data = mcause_data;
                `CSR_IDX_MTVAL:      o_data = mtval_data;
                `CSR_IDX_MIP:        o_data = csr_word_t'(mip_data);
                default:             o_data = '0;   // Unknown index
            endcase
        end
    end

endmodule

// ==== rv_csr_unit.sv ====
`timescale 1ns/1ps

module rv_csr_unit
#(
    parameter int EXTENSION_C      = 0,
    parameter int EXTENSION_Zicntr = 0,
    parameter int EXTENSION_Zihpm  = 0
)
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_csr_valid,
    input  rv_csr_pkg::csr_funct3_t i_funct3,
    input  rv_csr_pkg::csr_addr_t   i_csr_addr,
    input  logic [4:0]              i_rs1_idx,
    input  rv_csr_pkg::csr_word_t   i_rs1_data,
    input  rv_csr_pkg::csr_word_t   i_pc,
    input  logic                    i_ebreak,
    input  logic                    i_irq_external,
    input  logic                    i_irq_timer,
    input  logic                    i_irq_soft,
    output rv_csr_pkg::csr_word_t   o_rd_data,
    output logic                    o_illegal,
    output rv_csr_pkg::csr_word_t   o_ret_addr,
    output rv_csr_pkg::csr_word_t   o_trap_pc,
    output logic                    o_irq,
    output rv_csr_pkg::cause_code_t o_irq_cause
);
    import rv_csr_pkg::*;

    logic      csr_sel;                                 // Decoder to CSR file
    csr_idx_t  csr_idx;
    csr_word_t csr_data;
    logic      csr_write;
    logic      csr_set;
    logic      csr_clear;
    logic      enable_external;                         // mie bits to interrupt controller
    logic      enable_timer;
    logic      enable_soft;
    logic      pending_external;                        // Synchronized lines back into mip
    logic      pending_timer;
    logic      pending_soft;

    rv_csr_access u_access
    (
        .i_csr_valid (i_csr_valid),
        .i_funct3    (i_funct3),
        .i_csr_addr  (i_csr_addr),
        .i_rs1_idx   (i_rs1_idx),
        .i_rs1_data  (i_rs1_data),
        .o_sel       (csr_sel),
        .o_idx       (csr_idx),
        .o_data      (csr_data),
        .o_write     (csr_write),
        .o_set       (csr_set),
        .o_clear     (csr_clear),
        .o_illegal   (o_illegal)
    );

    rv_csr_machine
    #(
        .EXTENSION_C      (EXTENSION_C),
        .EXTENSION_Zicntr (EXTENSION_Zicntr),
        .EXTENSION_Zihpm  (EXTENSION_Zihpm)
    )
    u_machine
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_sel              (csr_sel),
        .i_idx              (csr_idx),
        .i_data             (csr_data),
        .i_write            (csr_write),
        .i_set              (csr_set),
        .i_clear            (csr_clear),
        .i_pc               (i_pc),
        .i_ebreak           (i_ebreak),
        .i_pending_external (pending_external),
        .i_pending_timer    (pending_timer),
        .i_pending_soft     (pending_soft),
        .o_enable_external  (enable_external),
        .o_enable_timer     (enable_timer),
        .o_enable_soft      (enable_soft),
        .o_ret_addr         (o_ret_addr),
        .o_trap_pc          (o_trap_pc),
        .o_data             (o_rd_data)                 // Old value, before update
    );

    rv_int_ctrl u_int_ctrl
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_irq_external     (i_irq_external),
        .i_irq_timer        (i_irq_timer),
        .i_irq_soft         (i_irq_soft),
        .i_enable_external  (enable_external),
        .i_enable_timer     (enable_timer),
        .i_enable_soft      (enable_soft),
        .o_pending_external (pending_external),
        .o_pending_timer    (pending_timer),
        .o_pending_soft     (pending_soft),
        .o_irq              (o_irq),
        .o_irq_cause        (o_irq_cause)
    );

endmodule

// ==== tb_rv_csr_unit.sv ====
`timescale 1ns/1ps

`include "rv_csr_consts.svh"

module tb_rv_csr_unit;
    import rv_csr_pkg::*;

    localparam int EXT_C          = 1;
    localparam int ZICNTR         = 1;
    localparam int ZIHPM          = 0;
    localparam int WRITE_ROUNDS   = 8;
    localparam int SETCLR_OPS     = 20;
    localparam int ILLEGAL_OPS    = 8;
    localparam int IRQ_STEPS      = 40;
    // Reset, reset reads, each test loop, fixed sequences, margin
    localparam int PLANNED_CYCLES = 3 + 11 + WRITE_ROUNDS * 10 + SETCLR_OPS * 2 + 5
                                  + ILLEGAL_OPS * 2 + 16 + IRQ_STEPS * 2 + 50;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;
    localparam csr_word_t MISA_VALUE = 32'h4000_0104;   // MXL=1, I and C

    logic        i_clk;
    logic        i_reset_n;
    logic        i_csr_valid;
    csr_funct3_t i_funct3;
    csr_addr_t   i_csr_addr;
    logic [4:0]  i_rs1_idx;
    csr_word_t   i_rs1_data;
    csr_word_t   i_pc;
    logic        i_ebreak;
    logic        i_irq_external;
    logic        i_irq_timer;
    logic        i_irq_soft;
    csr_word_t   o_rd_data;
    logic        o_illegal;
    csr_word_t   o_ret_addr;
    csr_word_t   o_trap_pc;
    logic        o_irq;
    cause_code_t o_irq_cause;

    csr_word_t   shadow [256];                          // Reference CSR values by index
    logic [2:0]  pend_model;                            // Synchronized lines {ext, timer, soft}
    logic [2:0]  irq_lines;                             // Raw lines for the next cycle
    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    logic        check_en;                              // Expectations ready for this cycle
    logic        exp_valid;
    logic        exp_illegal;
    logic        exp_irq;
    csr_word_t   exp_rd;
    csr_word_t   exp_ret;
    csr_word_t   exp_trap;
    cause_code_t exp_cause;

    csr_idx_t defined_regs [11] = '{`CSR_IDX_MSTATUS, `CSR_IDX_MISA, `CSR_IDX_MIE,
                                    `CSR_IDX_MTVEC, `CSR_IDX_MCOUNTEREN, `CSR_IDX_MSTATUSH,
                                    `CSR_IDX_MSCRATCH, `CSR_IDX_MEPC, `CSR_IDX_MCAUSE,
                                    `CSR_IDX_MTVAL, `CSR_IDX_MIP};
    csr_idx_t rw_regs [5] = '{`CSR_IDX_MSCRATCH, `CSR_IDX_MTVAL, `CSR_IDX_MTVEC,
                              `CSR_IDX_MIE, `CSR_IDX_MCOUNTEREN};

    rv_csr_unit
    #(
        .EXTENSION_C      (EXT_C),
        .EXTENSION_Zicntr (ZICNTR),
        .EXTENSION_Zihpm  (ZIHPM)
    )
    i_dut
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_csr_valid    (i_csr_valid),
        .i_funct3       (i_funct3),
        .i_csr_addr     (i_csr_addr),
        .i_rs1_idx      (i_rs1_idx),
        .i_rs1_data     (i_rs1_data),
        .i_pc           (i_pc),
        .i_ebreak       (i_ebreak),
        .i_irq_external (i_irq_external),
        .i_irq_timer    (i_irq_timer),
        .i_irq_soft     (i_irq_soft),
        .o_rd_data      (o_rd_data),
        .o_illegal      (o_illegal),
        .o_ret_addr     (o_ret_addr),
        .o_trap_pc      (o_trap_pc),
        .o_irq          (o_irq),
        .o_irq_cause    (o_irq_cause)
    );

    always #2 i_clk = ~i_clk;                           // 4 ns period

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic rand_bits(input int n, output csr_word_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};               // One step per bit
        end
    endtask

    function automatic csr_word_t width_mask(input csr_idx_t idx);
        case (idx)
            `CSR_IDX_MIE:        return 32'h0000_0FFF;
            `CSR_IDX_MCOUNTEREN: return (ZICNTR ? 32'h7 : 32'h0) | (ZIHPM ? 32'hFFFF_FFF8 : 32'h0);
            `CSR_IDX_MSTATUS, `CSR_IDX_MSTATUSH, `CSR_IDX_MTVEC,
            `CSR_IDX_MSCRATCH, `CSR_IDX_MTVAL, `CSR_IDX_MEPC:
                                 return 32'hFFFF_FFFF;
            default:             return 32'h0;          // Read-only or unmapped
        endcase
    endfunction

    function automatic logic f3_defined(input csr_funct3_t f3);
        case (f3)
            `CSR_F3_RW, `CSR_F3_RS, `CSR_F3_RC,
            `CSR_F3_RWI, `CSR_F3_RSI, `CSR_F3_RCI: return 1'b1;
            default:                               return 1'b0;
        endcase
    endfunction

    // New CSR value after one Zicsr access
    function automatic csr_word_t ref_csr(input csr_word_t old, input csr_funct3_t f3,
                                          input logic [4:0] rs1, input csr_word_t data,
                                          input csr_word_t mask);
        csr_word_t operand;
        operand = data;
        if (f3 == `CSR_F3_RWI || f3 == `CSR_F3_RSI || f3 == `CSR_F3_RCI)
            operand = {27'b0, rs1};                     // Zero-extended uimm
        case (f3)
            `CSR_F3_RW, `CSR_F3_RWI: return operand & mask;
            `CSR_F3_RS, `CSR_F3_RSI: return (rs1 != 0) ? (old | (operand & mask)) : old;
            `CSR_F3_RC, `CSR_F3_RCI: return (rs1 != 0) ? (old & ~(operand & mask)) : old;
            default:                 return old;
        endcase
    endfunction

    function automatic csr_word_t ref_read(input csr_idx_t idx);
        csr_word_t mip;
        mip = '0;
        mip[`IRQ_CODE_EXTERNAL] = pend_model[2];
        mip[`IRQ_CODE_TIMER]    = pend_model[1];
        mip[`IRQ_CODE_SOFT]     = pend_model[0];
        case (idx)
            `CSR_IDX_MISA: return MISA_VALUE;
            `CSR_IDX_MIP:  return mip;
            default:       return shadow[idx];          // Holes stay zero
        endcase
    endfunction

    function automatic csr_word_t ref_trap(input csr_word_t tvec, input csr_word_t cause);
        csr_word_t base;
        base = {tvec[31:2], 2'b00};
        case (tvec[1:0])
            `MTVEC_MODE_DIRECT:   return base;
            `MTVEC_MODE_VECTORED: return base + 4 * cause;
            default:              return '0;
        endcase
    endfunction

    function automatic logic [2:0] enabled_pending(input logic [2:0] pend, input csr_word_t mie);
        return pend & {mie[`IRQ_CODE_EXTERNAL], mie[`IRQ_CODE_TIMER], mie[`IRQ_CODE_SOFT]};
    endfunction

    function automatic cause_code_t ref_irq_cause(input logic [2:0] active);
        if (active[2])
            return cause_code_t'(`IRQ_CODE_EXTERNAL);   // External first
        else if (active[0])
            return cause_code_t'(`IRQ_CODE_SOFT);       // Then soft
        else if (active[1])
            return cause_code_t'(`IRQ_CODE_TIMER);
        return '0;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input csr_word_t act, input csr_word_t exp, input string what);
        if (act !== exp)
        begin
            $display("mismatch at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, act, exp);
            abort_run();
        end
    endtask

    task automatic check_cause(input cause_code_t act, input cause_code_t exp,
                               input string what);
        if (act !== exp)
        begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string what);
        if (act !== exp)
        begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, act, exp);
            abort_run();
        end
    endtask

    // Drive one cycle, set expectations from the model, then advance the model
    task automatic drive_cycle(input logic valid, input csr_funct3_t f3, input csr_addr_t addr,
                               input logic [4:0] rs1, input csr_word_t data,
                               input logic ebreak, input csr_word_t pc);
        csr_idx_t idx;
        logic     legal;
        idx   = addr[7:0];
        legal = valid && (addr[11:8] == `CSR_MACHINE_PAGE) && f3_defined(f3);
        @(negedge i_clk);
        exp_valid   = valid;
        exp_illegal = valid && !legal;
        exp_rd      = legal ? ref_read(idx) : '0;       // Old value before the edge
        exp_ret     = shadow[`CSR_IDX_MEPC];
        exp_trap    = ref_trap(shadow[`CSR_IDX_MTVEC], shadow[`CSR_IDX_MCAUSE]);
        exp_irq     = |enabled_pending(pend_model, shadow[`CSR_IDX_MIE]);
        exp_cause   = ref_irq_cause(enabled_pending(pend_model, shadow[`CSR_IDX_MIE]));
        i_csr_valid    = valid;
        i_funct3       = f3;
        i_csr_addr     = addr;
        i_rs1_idx      = rs1;
        i_rs1_data     = data;
        i_ebreak       = ebreak;
        i_pc           = pc;
        i_irq_external = irq_lines[2];
        i_irq_timer    = irq_lines[1];
        i_irq_soft     = irq_lines[0];
        check_en       = 1'b1;
        if (legal)
            shadow[idx] = ref_csr(shadow[idx], f3, rs1, data, width_mask(idx));
        if (ebreak)
        begin
            shadow[`CSR_IDX_MEPC]   = pc;               // Trap overrides a mepc write
            shadow[`CSR_IDX_MCAUSE] = `CAUSE_BREAKPOINT;
        end
        pend_model = irq_lines;                         // One register stage
    endtask

    task automatic csr_op(input csr_funct3_t f3, input csr_idx_t idx, input logic [4:0] rs1,
                          input csr_word_t data);
        drive_cycle(1'b1, f3, {`CSR_MACHINE_PAGE, idx}, rs1, data, 1'b0, '0);
    endtask

    task automatic read_csr(input csr_idx_t idx);
        csr_op(`CSR_F3_RS, idx, 5'd0, '0);              // rs1=x0 reads without side effect
    endtask

    always @(negedge i_clk)
    begin
        #1;                                             // Mid low phase with inputs settled
        if (check_en)
        begin
            check_en = 1'b0;
            if (exp_valid)
                check_word(o_rd_data, exp_rd, "o_rd_data");
            check_bit(o_illegal, exp_illegal, "o_illegal");
            check_word(o_ret_addr, exp_ret, "o_ret_addr");
            check_word(o_trap_pc, exp_trap, "o_trap_pc");
            check_bit(o_irq, exp_irq, "o_irq");
            check_cause(o_irq_cause, exp_cause, "o_irq_cause");
        end
    end

    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial
    begin
        csr_word_t   w;
        csr_word_t   r;
        csr_word_t   pc;
        csr_idx_t    idx;
        logic [3:0]  page;
        i_clk          = 1'b0;
        i_reset_n      = 1'b0;
        i_csr_valid    = 1'b0;
        i_funct3       = '0;
        i_csr_addr     = '0;
        i_rs1_idx      = '0;
        i_rs1_data     = '0;
        i_pc           = '0;
        i_ebreak       = 1'b0;
        i_irq_external = 1'b0;
        i_irq_timer    = 1'b0;
        i_irq_soft     = 1'b0;
        lfsr_state     = 16'd61974;
        irq_lines      = '0;
        pend_model     = '0;
        check_en       = 1'b0;
        for (int i = 0; i < 256; i++)
            shadow[i] = '0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;

        for (int i = 0; i < 11; i++)                    // Reset values, misa constant
            read_csr(defined_regs[i]);

        for (int n = 0; n < WRITE_ROUNDS; n++)          // RW and RWI, masked read-back
            for (int k = 0; k < 5; k++)
            begin
                rand_bits(32, w);
                rand_bits(5, r);
                csr_op(n[0] ? `CSR_F3_RWI : `CSR_F3_RW, rw_regs[k], r[4:0], w);
                read_csr(rw_regs[k]);
            end

        for (int n = 0; n < SETCLR_OPS; n++)
        begin
            rand_bits(3, r);
            idx = rw_regs[r % 5];
            rand_bits(2, w);                            // Picks RS, RC, RSI or RCI
            rand_bits(5, r);
            rand_bits(32, pc);
            csr_op({w[1], 1'b1, w[0]}, idx, r[4:0], pc);
            read_csr(idx);
        end
        csr_op(`CSR_F3_RS, `CSR_IDX_MSCRATCH, 5'd0, 32'hFFFF_FFFF);  // Zero source
        csr_op(`CSR_F3_RW, `CSR_IDX_MIE, 5'd1, 32'h0000_0FFF);
        csr_op(`CSR_F3_RC, `CSR_IDX_MIE, 5'd0, 32'hFFFF_FFFF);
        read_csr(`CSR_IDX_MSCRATCH);
        read_csr(`CSR_IDX_MIE);

        for (int n = 0; n < ILLEGAL_OPS; n++)
        begin
            rand_bits(3, r);
            idx = rw_regs[r % 5];
            rand_bits(4, r);
            page = r[3:0];
            if (page == `CSR_MACHINE_PAGE)
                page = page ^ 4'h8;                     // Force off the machine page
            rand_bits(32, w);
            if (n[0])
                drive_cycle(1'b1, n[1] ? 3'd0 : 3'd4, {`CSR_MACHINE_PAGE, idx}, 5'd1, w,
                            1'b0, '0);                  // Undefined funct3
            else
                drive_cycle(1'b1, `CSR_F3_RW, {page, idx}, 5'd1, w, 1'b0, '0);
            read_csr(idx);
        end

        rand_bits(32, w);
        csr_op(`CSR_F3_RW, `CSR_IDX_MTVEC, 5'd1, {w[31:2], `MTVEC_MODE_DIRECT});
        rand_bits(32, pc);
        drive_cycle(1'b0, 3'd0, '0, 5'd0, '0, 1'b1, pc);    // Ebreak, direct target
        read_csr(`CSR_IDX_MEPC);
        read_csr(`CSR_IDX_MCAUSE);
        csr_op(`CSR_F3_RW, `CSR_IDX_MTVEC, 5'd1, {w[31:2], `MTVEC_MODE_VECTORED});
        read_csr(`CSR_IDX_MTVEC);                       // Target now base plus 12
        rand_bits(32, pc);
        rand_bits(32, w);
        drive_cycle(1'b1, `CSR_F3_RW, {`CSR_MACHINE_PAGE, `CSR_IDX_MEPC}, 5'd1, w, 1'b1, pc);
        read_csr(`CSR_IDX_MEPC);
        csr_op(`CSR_F3_RW, `CSR_IDX_MEPC, 5'd1, w);
        read_csr(`CSR_IDX_MEPC);
        csr_op(`CSR_F3_RW, `CSR_IDX_MTVEC, 5'd1, {w[31:2], 2'b11});  // Reserved mode
        read_csr(`CSR_IDX_MCAUSE);

        rand_bits(12, w);
        csr_op(`CSR_F3_RW, `CSR_IDX_MIE, 5'd1, w);
        for (int n = 0; n < IRQ_STEPS; n++)
        begin
            if (n % 8 == 7)
            begin
                rand_bits(12, w);
                csr_op(`CSR_F3_RW, `CSR_IDX_MIE, 5'd1, w);
            end
            rand_bits(3, r);
            irq_lines = r[2:0];
            read_csr(`CSR_IDX_MIP);
        end
        csr_op(`CSR_F3_RW, `CSR_IDX_MIE, 5'd1, 32'h0000_0888);  // MEIE, MTIE, MSIE
        irq_lines = 3'b111;
        read_csr(`CSR_IDX_MIP);
        read_csr(`CSR_IDX_MIP);                         // External wins
        csr_op(`CSR_F3_RC, `CSR_IDX_MIE, 5'd1, 32'h0000_0800);
        csr_op(`CSR_F3_RC, `CSR_IDX_MIE, 5'd1, 32'h0000_0008);  // Soft, then timer
        irq_lines = 3'b000;
        read_csr(`CSR_IDX_MIP);
        read_csr(`CSR_IDX_MIP);
        @(posedge i_clk);                               // Let the last compare run

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== rv_csr.f ====
+incdir+.
rv_csr_pkg.sv
rv_csr_reg.sv
rv_csr_access.sv
rv_int_ctrl.sv
rv_csr_machine.sv
rv_csr_unit.sv
tb_rv_csr_unit.sv
